/* vlog.f */
+incdir+rtl
rtl/axi_atop_pkg.sv
rtl/stream_register.sv
rtl/axi_atop_filter.sv
rtl/axi_sim_mem.sv
rtl/axi_atop_subsys.sv
dv/axi_atop_checker.sv
dv/axi_atop_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module axi_atop_tb -f vlog.f -o axi_atop_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/axi_atop_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation ended with status $sim_status"
  exit "$sim_status"
fi

exit 0

/* dv/axi_atop_tb.sv */
// Table-driven testbench for the ATOP filter in front of the AXI memory.
`timescale 1ns/1ps
`include "axi_atop_defines.svh"

module axi_atop_tb;

  import axi_atop_pkg::*;

  typedef enum logic [1:0] {KIND_WRITE, KIND_READ, KIND_ATOMIC} kind_e;

  // One stimulus row; expected responses follow from kind and atop.
  typedef struct packed {
    kind_e kind;
    atop_t atop;
    id_t   id;
    addr_t addr;
    len_t  len;
    data_t base;
  } row_t;

  localparam int          NUM_ROWS   = 12;
  localparam int unsigned WORD_BYTES = `AXI_DATA_W / 8;

  string row_name [NUM_ROWS] = '{
    "wr_burst", "rd_burst", "atomic_store", "rd_after_store",
    "atomic_load", "atomic_swap", "atomic_cmp", "wr_pending",
    "load_after_wr", "rd_pending", "wr_wrap", "rd_wrap"
  };

  // Columns: kind, atop, id, byte address, len, write data base.
  row_t rows [NUM_ROWS] = '{
    '{KIND_WRITE,  6'h00, 4'h1, 16'h0040, 8'd3, 32'h1000_0000},
    '{KIND_READ,   6'h00, 4'h2, 16'h0040, 8'd3, 32'h0000_0000},
    '{KIND_ATOMIC, 6'h10, 4'h3, 16'h0040, 8'd1, 32'hDEAD_0000},
    '{KIND_READ,   6'h00, 4'h4, 16'h0040, 8'd3, 32'h0000_0000},
    '{KIND_ATOMIC, 6'h20, 4'h5, 16'h0080, 8'd2, 32'hBEEF_0000},
    '{KIND_ATOMIC, 6'h30, 4'h6, 16'h0090, 8'd0, 32'hCAFE_0000},
    '{KIND_ATOMIC, 6'h31, 4'h7, 16'h00A0, 8'd1, 32'hF00D_0000},
    '{KIND_WRITE,  6'h00, 4'h8, 16'h0100, 8'd4, 32'h2000_0000},
    '{KIND_ATOMIC, 6'h20, 4'h9, 16'h0100, 8'd1, 32'hBAD0_0000},
    '{KIND_READ,   6'h00, 4'hA, 16'h0100, 8'd4, 32'h0000_0000},
    '{KIND_WRITE,  6'h00, 4'hB, 16'h03F8, 8'd3, 32'h3000_0000},
    '{KIND_READ,   6'h00, 4'hC, 16'h03F8, 8'd3, 32'h0000_0000}
  };

  logic     clk_i;
  logic     rst_ni;
  logic     s_aw_valid, s_aw_ready;
  aw_chan_t s_aw;
  logic     s_w_valid, s_w_ready;
  w_chan_t  s_w;
  logic     s_b_valid;
  logic     s_b_ready = 1'b0;
  b_chan_t  s_b;
  logic     s_ar_valid, s_ar_ready;
  ar_chan_t s_ar;
  logic     s_r_valid;
  logic     s_r_ready = 1'b0;
  r_chan_t  s_r;

  integer seed        = 57350;
  bit     run_passed  = 1'b0;
  bit     fail_printed = 1'b0;

  // Reference memory and responses still owed by the DUT.
  data_t   ref_mem [`MEM_WORDS];
  b_chan_t exp_b_q [$];
  string   exp_b_name [$];
  r_chan_t exp_r_q [$];
  string   exp_r_name [$];

  axi_atop_subsys axi_atop_subsys_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_aw_valid_i (s_aw_valid),
    .s_aw_ready_o (s_aw_ready),
    .s_aw_i       (s_aw),
    .s_w_valid_i  (s_w_valid),
    .s_w_ready_o  (s_w_ready),
    .s_w_i        (s_w),
    .s_b_valid_o  (s_b_valid),
    .s_b_ready_i  (s_b_ready),
    .s_b_o        (s_b),
    .s_ar_valid_i (s_ar_valid),
    .s_ar_ready_o (s_ar_ready),
    .s_ar_i       (s_ar),
    .s_r_valid_o  (s_r_valid),
    .s_r_ready_i  (s_r_ready),
    .s_r_o        (s_r)
  );

  // 10 ns clock.
  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Random B and R back-pressure, about one stall in four.
  always begin
    @(posedge clk_i);
    #1;
    s_b_ready = ($random(seed) % 4) != 0;
    s_r_ready = ($random(seed) % 4) != 0;
  end

  // Word slot of a beat; byte address over word size, wrapping at the depth.
  function automatic int unsigned word_index(addr_t addr, int unsigned beat);
    return (int'(addr) / WORD_BYTES + beat) % `MEM_WORDS;
  endfunction

  task automatic abort_run(string what);
    $display("%s", what);
    fail_printed = 1'b1;
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_b(string name, b_chan_t exp, b_chan_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected B id=%0h resp=%0h, actual B id=%0h resp=%0h",
                          name, exp.id, exp.resp, act.id, act.resp));
    end
  endtask

  task automatic check_r(string name, r_chan_t exp, r_chan_t act);
    if (act !== exp) begin
      abort_run($sformatf({"Mismatch %s: expected R id=%0h data=%h resp=%0h last=%0b,",
                           " actual R id=%0h data=%h resp=%0h last=%0b"},
                          name, exp.id, exp.data, exp.resp, exp.last,
                          act.id, act.data, act.resp, act.last));
    end
  endtask

  task automatic collect_b(b_chan_t act);
    b_chan_t exp;
    string   name;
    if (exp_b_q.size() == 0) begin
      abort_run($sformatf("B response with id %0h arrived while no write was open", act.id));
    end else begin
      exp  = exp_b_q.pop_front();
      name = exp_b_name.pop_front();
      check_b(name, exp, act);
    end
  endtask

  task automatic collect_r(r_chan_t act);
    r_chan_t exp;
    string   name;
    if (exp_r_q.size() == 0) begin
      abort_run($sformatf("R beat with id %0h arrived while no read was open", act.id));
    end else begin
      exp  = exp_r_q.pop_front();
      name = exp_r_name.pop_front();
      check_r(name, exp, act);
    end
  endtask

  // Handshakes are sampled at the falling edge, where all signals have settled.
  always @(negedge clk_i) begin
    if (rst_ni && s_b_valid && s_b_ready) begin
      collect_b(s_b);
    end
    if (rst_ni && s_r_valid && s_r_ready) begin
      collect_r(s_r);
    end
  end

  task automatic send_aw(aw_chan_t aw);
    s_aw       = aw;
    s_aw_valid = 1'b1;
    @(negedge clk_i);
    while (!s_aw_ready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    s_aw_valid = 1'b0;
  endtask

  task automatic send_w_burst(data_t base, len_t len);
    for (int unsigned beat = 0; beat <= len; beat++) begin
      s_w       = '{data: base + data_t'(beat), strb: '1, last: (beat == len)};
      s_w_valid = 1'b1;
      @(negedge clk_i);
      while (!s_w_ready) @(negedge clk_i);
      @(posedge clk_i);
      #1;
    end
    s_w_valid = 1'b0;
  endtask

  task automatic send_ar(ar_chan_t ar);
    s_ar       = ar;
    s_ar_valid = 1'b1;
    @(negedge clk_i);
    while (!s_ar_ready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    s_ar_valid = 1'b0;
  endtask

  // Wait until every owed response came back.
  task automatic drain();
    while (exp_b_q.size() != 0 || exp_r_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_row(int idx);
    row_t     row;
    aw_chan_t aw;
    ar_chan_t ar;
    row = rows[idx];
    case (row.kind)
      KIND_WRITE, KIND_ATOMIC: begin
        aw = '{id: row.id, addr: row.addr, len: row.len, size: 3'($clog2(WORD_BYTES)),
               burst: BURST_INCR, atop: row.atop};
        exp_b_name.push_back(row_name[idx]);
        if (row.kind == KIND_WRITE) begin
          for (int unsigned beat = 0; beat <= row.len; beat++) begin
            ref_mem[word_index(row.addr, beat)] = row.base + data_t'(beat);
          end
          exp_b_q.push_back('{id: row.id, resp: RESP_OKAY});
        end else begin
          // Memory stays untouched; every class but store owes len+1 error beats.
          exp_b_q.push_back('{id: row.id, resp: RESP_SLVERR});
          if (row.atop[5:4] != ATOP_ATOMICSTORE) begin
            for (int unsigned beat = 0; beat <= row.len; beat++) begin
              exp_r_q.push_back('{id: row.id, data: '0, resp: RESP_SLVERR,
                                  last: (beat == row.len)});
              exp_r_name.push_back(row_name[idx]);
            end
          end
        end
        // AW and W go out side by side; the B is left outstanding.
        fork
          send_aw(aw);
          send_w_burst(row.base, row.len);
        join
      end
      KIND_READ: begin
        drain();
        for (int unsigned beat = 0; beat <= row.len; beat++) begin
          exp_r_q.push_back('{id: row.id, data: ref_mem[word_index(row.addr, beat)],
                              resp: RESP_OKAY, last: (beat == row.len)});
          exp_r_name.push_back(row_name[idx]);
        end
        ar = '{id: row.id, addr: row.addr, len: row.len, size: 3'($clog2(WORD_BYTES)),
               burst: BURST_INCR};
        send_ar(ar);
        drain();
      end
      default: begin
        abort_run($sformatf("Row %s has an unknown kind", row_name[idx]));
      end
    endcase
  endtask

  initial begin
    s_aw_valid = 1'b0;
    s_aw       = '0;
    s_w_valid  = 1'b0;
    s_w        = '0;
    s_ar_valid = 1'b0;
    s_ar       = '0;
    rst_ni     = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    drain();
    // Quiet window, a stray extra beat would still be caught here.
    repeat (10) @(posedge clk_i);
    run_passed = 1'b1;
    $display("Verification passed");
    $finish;
  end

  // Budget of 4 cycles a beat and 30 a row, plus reset and the quiet window.
  initial begin : watchdog
    int unsigned limit;
    limit = 3 + 10;
    for (int i = 0; i < NUM_ROWS; i++) begin
      limit += (int'(rows[i].len) + 1) * 4 + 30;
    end
    repeat (limit) @(posedge clk_i);
    abort_run($sformatf("Timeout after %0d cycles, %0d B and %0d R responses never arrived",
                        limit, exp_b_q.size(), exp_r_q.size()));
  end

  // An assertion that stops the run still ends with the failure line.
  final begin
    if (!run_passed && !fail_printed) begin
      $display("Verification failed");
    end
  end

endmodule

/* dv/axi_atop_checker.sv */
// Bound protocol assertions on the ATOP filter's upstream and downstream ports.
`timescale 1ns/1ps
`include "axi_atop_defines.svh"

module axi_atop_checker #(
  parameter int unsigned CNT_W = $clog2(`AXI_MAX_WRITE_TXNS + 1)
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   s_aw_valid_i,
  input axi_atop_pkg::aw_chan_t s_aw_i,
  input logic                   m_aw_valid_i,
  input logic                   m_aw_ready_i,
  input axi_atop_pkg::aw_chan_t m_aw_i,
  input logic                   m_w_valid_i,
  input logic                   m_w_ready_i,
  input axi_atop_pkg::w_chan_t  m_w_i,
  input logic                   s_b_valid_i,
  input logic                   s_b_ready_i,
  input axi_atop_pkg::b_chan_t  s_b_i,
  input logic                   s_r_valid_i,
  input logic                   s_r_ready_i,
  input axi_atop_pkg::r_chan_t  s_r_i
);

  logic [CNT_W-1:0] open_q;

  // Bursts open on the memory side, AW handshakes minus last W handshakes.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= '0;
    end else begin
      open_q <= open_q + CNT_W'(m_aw_valid_i && m_aw_ready_i)
                       - CNT_W'(m_w_valid_i && m_w_ready_i && m_w_i.last);
    end
  end

  // Memory only sees AWs that were plain upstream, with atop cleared.
  aw_atop_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_aw_valid_i |-> (s_aw_valid_i && (s_aw_i.atop == '0) && (m_aw_i.atop == '0)))
    else $error("Memory-side AW carries a non-zero atop field");

  // Stalled B keeps valid and payload.
  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (s_b_valid_i && !s_b_ready_i) |=> (s_b_valid_i && $stable(s_b_i)))
    else $error("Upstream B changed or dropped before its handshake");

  // Stalled R keeps valid and payload.
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (s_r_valid_i && !s_r_ready_i) |=> (s_r_valid_i && $stable(s_r_i)))
    else $error("Upstream R changed or dropped before its handshake");

  // W data only follows an AW that already went down.
  w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (open_q == '0) |-> !m_w_valid_i)
    else $error("Memory-side W valid with no write burst open");

endmodule

bind axi_atop_filter axi_atop_checker u_atop_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .s_aw_valid_i (s_aw_valid_i),
  .s_aw_i       (s_aw_i),
  .m_aw_valid_i (m_aw_valid_o),
  .m_aw_ready_i (m_aw_ready_i),
  .m_aw_i       (m_aw_o),
  .m_w_valid_i  (m_w_valid_o),
  .m_w_ready_i  (m_w_ready_i),
  .m_w_i        (m_w_o),
  .s_b_valid_i  (s_b_valid_o),
  .s_b_ready_i  (s_b_ready_i),
  .s_b_i        (s_b_o),
  .s_r_valid_i  (s_r_valid_o),
  .s_r_ready_i  (s_r_ready_i),
  .s_r_i        (s_r_o)
);

/* rtl/axi_atop_subsys.sv */
// Subsystem top placing the ATOP filter in front of the AXI memory.
`timescale 1ns/1ps

module axi_atop_subsys (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   s_aw_valid_i,
  output logic                   s_aw_ready_o,
  input  axi_atop_pkg::aw_chan_t s_aw_i,
  input  logic                   s_w_valid_i,
  output logic                   s_w_ready_o,
  input  axi_atop_pkg::w_chan_t  s_w_i,
  output logic                   s_b_valid_o,
  input  logic                   s_b_ready_i,
  output axi_atop_pkg::b_chan_t  s_b_o,
  input  logic                   s_ar_valid_i,
  output logic                   s_ar_ready_o,
  input  axi_atop_pkg::ar_chan_t s_ar_i,
  output logic                   s_r_valid_o,
  input  logic                   s_r_ready_i,
  output axi_atop_pkg::r_chan_t  s_r_o
);

  import axi_atop_pkg::*;

  // Filter to memory channels, atop always zero here.
  logic     m_aw_valid, m_aw_ready;
  aw_chan_t m_aw;
  logic     m_w_valid, m_w_ready;
  w_chan_t  m_w;
  logic     m_b_valid, m_b_ready;
  b_chan_t  m_b;
  logic     m_ar_valid, m_ar_ready;
  ar_chan_t m_ar;
  logic     m_r_valid, m_r_ready;
  r_chan_t  m_r;

  axi_atop_filter u_atop_filter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_ready_o (s_aw_ready_o),
    .s_aw_i       (s_aw_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .s_w_i        (s_w_i),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .s_b_o        (s_b_o),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_ar_i       (s_ar_i),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .s_r_o        (s_r_o),
    .m_aw_valid_o (m_aw_valid),
    .m_aw_ready_i (m_aw_ready),
    .m_aw_o       (m_aw),
    .m_w_valid_o  (m_w_valid),
    .m_w_ready_i  (m_w_ready),
    .m_w_o        (m_w),
    .m_b_valid_i  (m_b_valid),
    .m_b_ready_o  (m_b_ready),
    .m_b_i        (m_b),
    .m_ar_valid_o (m_ar_valid),
    .m_ar_ready_i (m_ar_ready),
    .m_ar_o       (m_ar),
    .m_r_valid_i  (m_r_valid),
    .m_r_ready_o  (m_r_ready),
    .m_r_i        (m_r)
  );

  axi_sim_mem u_sim_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_aw_valid_i (m_aw_valid),
    .s_aw_ready_o (m_aw_ready),
    .s_aw_i       (m_aw),
    .s_w_valid_i  (m_w_valid),
    .s_w_ready_o  (m_w_ready),
    .s_w_i        (m_w),
    .s_b_valid_o  (m_b_valid),
    .s_b_ready_i  (m_b_ready),
    .s_b_o        (m_b),
    .s_ar_valid_i (m_ar_valid),
    .s_ar_ready_o (m_ar_ready),
    .s_ar_i       (m_ar),
    .s_r_valid_o  (m_r_valid),
    .s_r_ready_i  (m_r_ready),
    .s_r_o        (m_r)
  );

endmodule

/* rtl/axi_sim_mem.sv */
// Word-addressed AXI memory slave serving one INCR read and one INCR write burst at a time.
`timescale 1ns/1ps
`include "axi_atop_defines.svh"

module axi_sim_mem (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   s_aw_valid_i,
  output logic                   s_aw_ready_o,
  input  axi_atop_pkg::aw_chan_t s_aw_i,
  input  logic                   s_w_valid_i,
  output logic                   s_w_ready_o,
  input  axi_atop_pkg::w_chan_t  s_w_i,
  output logic                   s_b_valid_o,
  input  logic                   s_b_ready_i,
  output axi_atop_pkg::b_chan_t  s_b_o,
  input  logic                   s_ar_valid_i,
  output logic                   s_ar_ready_o,
  input  axi_atop_pkg::ar_chan_t s_ar_i,
  output logic                   s_r_valid_o,
  input  logic                   s_r_ready_i,
  output axi_atop_pkg::r_chan_t  s_r_o
);

  import axi_atop_pkg::*;

  localparam int unsigned STRB_W = `AXI_DATA_W / 8;
  localparam int unsigned OFFS_W = $clog2(STRB_W);
  localparam int unsigned IDX_W  = $clog2(`MEM_WORDS);

  data_t mem_q [`MEM_WORDS];

  // Write burst state.
  logic             w_busy_q;
  id_t              w_id_q;
  logic [IDX_W-1:0] w_idx_q;
  logic             w_hs;
  logic             b_push_ready;

  // Read burst state.
  logic             r_busy_q;
  id_t              r_id_q;
  logic [IDX_W-1:0] r_idx_q;
  len_t             r_cnt_q;

  // One write burst at a time; the B register lets the next AW in early.
  assign s_aw_ready_o = !w_busy_q;
  // Last beat needs room for its B.
  assign s_w_ready_o  = w_busy_q && (!s_w_i.last || b_push_ready);
  assign w_hs         = s_w_valid_i && s_w_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_busy_q <= 1'b0;
      w_id_q   <= '0;
      w_idx_q  <= '0;
    end else if (s_aw_valid_i && s_aw_ready_o) begin
      w_busy_q <= 1'b1;
      w_id_q   <= s_aw_i.id;
      w_idx_q  <= s_aw_i.addr[OFFS_W +: IDX_W];
    end else if (w_hs) begin
      // Index wraps at the memory depth.
      w_idx_q <= w_idx_q + 1'b1;
      if (s_w_i.last) begin
        w_busy_q <= 1'b0;
      end
    end
  end

  // Byte-strobed store on each W handshake.
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      for (int unsigned i = 0; i < STRB_W; i++) begin
        if (s_w_i.strb[i]) begin
          mem_q[w_idx_q][8*i +: 8] <= s_w_i.data[8*i +: 8];
        end
      end
    end
  end

  // OKAY response, visible the cycle after the last beat.
  stream_register #(
    .T (b_chan_t)
  ) u_b_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (w_hs && s_w_i.last),
    .ready_o (b_push_ready),
    .data_i  ('{id: w_id_q, resp: RESP_OKAY}),
    .valid_o (s_b_valid_o),
    .ready_i (s_b_ready_i),
    .data_o  (s_b_o)
  );

  // Read side streams len+1 words.
  assign s_ar_ready_o = !r_busy_q;
  assign s_r_valid_o  = r_busy_q;
  assign s_r_o        = '{id: r_id_q, data: mem_q[r_idx_q], resp: RESP_OKAY,
                          last: (r_cnt_q == '0)};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_busy_q <= 1'b0;
      r_id_q   <= '0;
      r_idx_q  <= '0;
      r_cnt_q  <= '0;
    end else if (s_ar_valid_i && s_ar_ready_o) begin
      r_busy_q <= 1'b1;
      r_id_q   <= s_ar_i.id;
      r_idx_q  <= s_ar_i.addr[OFFS_W +: IDX_W];
      r_cnt_q  <= s_ar_i.len;
    end else if (s_r_valid_o && s_r_ready_i) begin
      if (r_cnt_q == '0) begin
        r_busy_q <= 1'b0;
      end else begin
        r_idx_q <= r_idx_q + 1'b1;
        r_cnt_q <= r_cnt_q - 1'b1;
      end
    end
  end

endmodule

/* rtl/axi_atop_filter.sv */
// ATOP filter that absorbs atomic AXI write bursts and answers them with SLVERR.
`timescale 1ns/1ps
`include "axi_atop_defines.svh"

module axi_atop_filter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Slave side, driven by the upstream master.
  input  logic                   s_aw_valid_i,
  output logic                   s_aw_ready_o,
  input  axi_atop_pkg::aw_chan_t s_aw_i,
  input  logic                   s_w_valid_i,
  output logic                   s_w_ready_o,
  input  axi_atop_pkg::w_chan_t  s_w_i,
  output logic                   s_b_valid_o,
  input  logic                   s_b_ready_i,
  output axi_atop_pkg::b_chan_t  s_b_o,
  input  logic                   s_ar_valid_i,
  output logic                   s_ar_ready_o,
  input  axi_atop_pkg::ar_chan_t s_ar_i,
  output logic                   s_r_valid_o,
  input  logic                   s_r_ready_i,
  output axi_atop_pkg::r_chan_t  s_r_o,
  // Master side, toward the slave without ATOP support.
  output logic                   m_aw_valid_o,
  input  logic                   m_aw_ready_i,
  output axi_atop_pkg::aw_chan_t m_aw_o,
  output logic                   m_w_valid_o,
  input  logic                   m_w_ready_i,
  output axi_atop_pkg::w_chan_t  m_w_o,
  input  logic                   m_b_valid_i,
  output logic                   m_b_ready_o,
  input  axi_atop_pkg::b_chan_t  m_b_i,
  output logic                   m_ar_valid_o,
  input  logic                   m_ar_ready_i,
  output axi_atop_pkg::ar_chan_t m_ar_o,
  input  logic                   m_r_valid_i,
  output logic                   m_r_ready_o,
  input  axi_atop_pkg::r_chan_t  m_r_i
);

  import axi_atop_pkg::*;

  localparam int unsigned      CNT_W    = $clog2(`AXI_MAX_WRITE_TXNS + 1);
  localparam logic [CNT_W-1:0] MAX_TXNS = CNT_W'(`AXI_MAX_WRITE_TXNS);

  typedef enum logic [2:0] {W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, INJECT_B, WAIT_R} w_state_e;
  typedef enum logic {R_FEEDTHROUGH, INJECT_R} r_state_e;

  w_state_e         w_state_q, w_state_d;
  r_state_e         r_state_q, r_state_d;
  logic [CNT_W-1:0] w_cnt_q, w_cnt_d;
  id_t              id_q, id_d;
  len_t             r_beats_q, r_beats_d;

  logic aw_atomic;
  logic aw_needs_r;
  logic absorb_ready;
  logic absorb_last;
  logic r_free;
  logic r_cmd_push_valid;
  logic r_cmd_push_ready;
  logic r_cmd_pop_valid;
  logic r_cmd_pop_ready;
  len_t r_cmd_len;

  // Atomic AW on the slave side.
  assign aw_atomic  = s_aw_valid_i && (s_aw_i.atop[5:4] != ATOP_NONE);
  // Every class except atomic store returns read data.
  assign aw_needs_r = s_aw_i.atop[5:4] != ATOP_ATOMICSTORE;

  // Hold the last atomic beat while a memory B waits upstream.
  // Otherwise the injected B would replace it under a stalled valid.
  assign absorb_ready = !s_w_i.last || !m_b_valid_i || s_b_ready_i;
  assign absorb_last  = s_w_valid_i && s_w_i.last && absorb_ready;

  // No memory R beat is left hanging at the slave side.
  assign r_free = !m_r_valid_i || s_r_ready_i;

  // Write side: AW, W and B.
  always_comb begin
    m_aw_o           = s_aw_i;
    m_aw_o.atop      = '0;
    m_w_o            = s_w_i;
    m_aw_valid_o     = 1'b0;
    s_aw_ready_o     = 1'b0;
    m_w_valid_o      = 1'b0;
    s_w_ready_o      = 1'b0;
    s_b_valid_o      = m_b_valid_i;
    s_b_o            = m_b_i;
    m_b_ready_o      = s_b_ready_i;
    id_d             = id_q;
    r_cmd_push_valid = 1'b0;
    w_state_d        = w_state_q;

    case (w_state_q)
      W_FEEDTHROUGH: begin
        // AW passes while below the open burst limit.
        if (w_cnt_q < MAX_TXNS) begin
          m_aw_valid_o = s_aw_valid_i;
          s_aw_ready_o = m_aw_ready_i;
        end
        // W only follows an AW that already went down.
        if (w_cnt_q != '0) begin
          m_w_valid_o = s_w_valid_i;
          s_w_ready_o = m_w_ready_i;
        end
        if (aw_atomic) begin
          // Atomic AW never reaches the memory.
          m_aw_valid_o = 1'b0;
          s_aw_ready_o = r_cmd_push_ready;
          if (r_cmd_push_ready) begin
            id_d             = s_aw_i.id;
            r_cmd_push_valid = aw_needs_r;
            if (w_cnt_q != '0) begin
              // Let open bursts drain their W data first.
              w_state_d = BLOCK_AW;
            end else begin
              s_w_ready_o = absorb_ready;
              w_state_d   = absorb_last ? INJECT_B : ABSORB_W;
            end
          end
        end
      end

      BLOCK_AW: begin
        if (w_cnt_q != '0) begin
          m_w_valid_o = s_w_valid_i;
          s_w_ready_o = m_w_ready_i;
        end else begin
          // Drained, the next W burst is the atomic one.
          s_w_ready_o = absorb_ready;
          w_state_d   = absorb_last ? INJECT_B : ABSORB_W;
        end
      end

      ABSORB_W: begin
        s_w_ready_o = absorb_ready;
        if (absorb_last) begin
          w_state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Memory B waits behind the injected error.
        m_b_ready_o = 1'b0;
        s_b_valid_o = 1'b1;
        s_b_o       = '{id: id_q, resp: RESP_SLVERR};
        if (s_b_ready_i) begin
          w_state_d = (r_cmd_pop_valid && !r_cmd_pop_ready) ? WAIT_R : W_FEEDTHROUGH;
        end
      end

      WAIT_R: begin
        // The ID stays in use until the read reply is done.
        if (!r_cmd_pop_valid) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end

      default: begin
        w_state_d = W_FEEDTHROUGH;
      end
    endcase
  end

  // Read side: AR always passes, R is fed through or injected.
  always_comb begin
    m_ar_o          = s_ar_i;
    m_ar_valid_o    = s_ar_valid_i;
    s_ar_ready_o    = m_ar_ready_i;
    s_r_o           = m_r_i;
    s_r_valid_o     = m_r_valid_i;
    m_r_ready_o     = s_r_ready_i;
    r_cmd_pop_ready = 1'b0;
    r_beats_d       = r_beats_q;
    r_state_d       = r_state_q;

    case (r_state_q)
      R_FEEDTHROUGH: begin
        // Switch only between beats so a stalled memory beat stays put.
        if (r_cmd_pop_valid && r_free) begin
          r_beats_d = r_cmd_len;
          r_state_d = INJECT_R;
        end
      end

      INJECT_R: begin
        m_r_ready_o = 1'b0;
        s_r_valid_o = 1'b1;
        s_r_o       = '{id: id_q, data: '0, resp: RESP_SLVERR, last: (r_beats_q == '0)};
        if (s_r_ready_i) begin
          if (r_beats_q == '0) begin
            r_cmd_pop_ready = 1'b1;
            r_state_d       = R_FEEDTHROUGH;
          end else begin
            r_beats_d = r_beats_q - 1'b1;
          end
        end
      end

      default: begin
        r_state_d = R_FEEDTHROUGH;
      end
    endcase
  end

  // Open bursts downstream: AW given minus W bursts completed.
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (m_aw_valid_o && m_aw_ready_i) begin
      w_cnt_d = w_cnt_d + 1'b1;
    end
    if (m_w_valid_o && m_w_ready_i && m_w_o.last) begin
      w_cnt_d = w_cnt_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_FEEDTHROUGH;
      r_state_q <= R_FEEDTHROUGH;
      w_cnt_q   <= '0;
      id_q      <= '0;
      r_beats_q <= '0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      id_q      <= id_d;
      r_beats_q <= r_beats_d;
    end
  end

  // Pending R injection, holds len of the atomic burst.
  stream_register #(
    .T (len_t)
  ) u_r_cmd (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (r_cmd_push_valid),
    .ready_o (r_cmd_push_ready),
    .data_i  (s_aw_i.len),
    .valid_o (r_cmd_pop_valid),
    .ready_i (r_cmd_pop_ready),
    .data_o  (r_cmd_len)
  );

endmodule

/* rtl/stream_register.sv */
// One-entry valid/ready register holding a single payload of any type.
`timescale 1ns/1ps

module stream_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  T     data_q;

  // Accept when empty, or when the held entry leaves this cycle.
  assign ready_o = !full_q || ready_i;
  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      data_q <= '0;
    end else if (ready_o) begin
      // Load on push, drop to empty on a plain pop.
      full_q <= valid_i;
      if (valid_i) begin
        data_q <= data_i;
      end
    end
  end

endmodule

/* rtl/axi_atop_pkg.sv */
// AXI channel payload types and protocol constants for the ATOP filter subsystem.
`include "axi_atop_defines.svh"

package axi_atop_pkg;

  // Basic field types.
  typedef logic [`AXI_ID_W-1:0]     id_t;
  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  typedef logic [7:0]               len_t;

  // Response codes.
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Atop field, class sits in bits 5:4.
  typedef logic [5:0] atop_t;
  localparam logic [1:0] ATOP_NONE        = 2'b00;
  localparam logic [1:0] ATOP_ATOMICSTORE = 2'b01;
  localparam logic [1:0] ATOP_ATOMICLOAD  = 2'b10;
  // Swap and compare share this class, bit 0 picks compare.
  localparam logic [1:0] ATOP_ATOMICSWAP  = 2'b11;

  // Only incrementing bursts are served.
  localparam logic [1:0] BURST_INCR = 2'b01;

  // Write address channel.
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    atop_t      atop;
  } aw_chan_t;

  // Read address channel.
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_chan_t;

  // Write data channel.
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response channel.
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Read data channel.
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

endpackage

/* rtl/axi_atop_defines.svh */
// AXI widths and sizing limits for the ATOP filter subsystem.
`ifndef AXI_ATOP_DEFINES_SVH
`define AXI_ATOP_DEFINES_SVH

// Transaction ID width in bits.
`define AXI_ID_W 4
// Byte address width in bits.
`define AXI_ADDR_W 16
// Data bus width in bits.
`define AXI_DATA_W 32

// Write bursts the filter lets stand open on the memory side.
`define AXI_MAX_WRITE_TXNS 2

// Memory depth in words, a power of two so the word index wraps.
`define MEM_WORDS 256

`endif
